/* verilog/scope_params.svh */
`ifndef SCOPE_PARAMS_SVH
`define SCOPE_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

`define PHASE_W         32            // phase accumulator
`define WAVE_W          12            // signed wave sample
`define PLOT_W          8             // offset binary plot byte

//////////////////////////////////////////////////////////////////////
// timing
//////////////////////////////////////////////////////////////////////

// board build ran the scope strobe at 70000 clocks
`define SAMPLE_DIV      16
`define SYMBOL_SAMPLES  8             // sample strobes per data symbol

// phase steps, per clock
`define BASE_INC        32'h0020_0000 // raw carrier, fsk space
`define FSK_INC         32'h0040_0000 // fsk mark, twice the carrier

//////////////////////////////////////////////////////////////////////
// data bit source
//////////////////////////////////////////////////////////////////////

`define LFSR_W          5
`define LFSR_SEED       5'h01
// x^5 + x^3 + 1, shift right, taps on bits 0 and 2
`define LFSR_TAPS       5'h05

//////////////////////////////////////////////////////////////////////
// keyboard event codes, number keys
//////////////////////////////////////////////////////////////////////

`define SC_MAKE_1       8'h16
`define SC_MAKE_2       8'h1E
`define SC_MAKE_3       8'h26
`define SC_MAKE_4       8'h25
`define SC_MAKE_5       8'h2E
`define SC_MAKE_6       8'h36
`define SC_MAKE_7       8'h3D
`define SC_MAKE_8       8'h3E

// break events carry the make code with bit 7 set
`define SC_BREAK_1      8'h96
`define SC_BREAK_2      8'h9E
`define SC_BREAK_3      8'hA6
`define SC_BREAK_4      8'hA5
`define SC_BREAK_5      8'hAE
`define SC_BREAK_6      8'hB6
`define SC_BREAK_7      8'hBD
`define SC_BREAK_8      8'hBE

`endif

/* verilog/scope_pkg.sv */
`default_nettype none

`include "scope_params.svh"

package scope_pkg;

   //////////////////////////////////////////////////////////////////////
   // keyboard side
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic       ready;        // one cycle strobe
      logic [7:0] event_type;   // make or break code
   } key_event_t;

   // bit n-1 is key n, so the vector indexes by key number
   typedef struct packed {
      logic key_8;
      logic key_7;
      logic key_6;
      logic key_5;
      logic key_4;
      logic key_3;
      logic key_2;
      logic key_1;
   } held_keys_t;

   //////////////////////////////////////////////////////////////////////
   // channel mode word
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      SAW       = 2'd0,
      TRIANGLE  = 2'd1,
      SQUARE    = 2'd2,
      RAMP_DOWN = 2'd3
   } wave_sel_e;

   typedef enum logic [1:0] {
      ASK    = 2'd0,
      FSK    = 2'd1,
      BPSK   = 2'd2,
      DIRECT = 2'd3
   } mod_sel_e;

   // raw channel reads a waveform, modulated channel reads a scheme
   typedef union packed {
      wave_sel_e wave;
      mod_sel_e  modulation;
   } chan_mode_u;

   typedef struct packed {
      logic [`PLOT_W-1:0] raw_plot;
      logic [`PLOT_W-1:0] mod_plot;
   } scope_sample_t;

endpackage

`default_nettype wire

/* verilog/keyboard_panel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module keyboard_panel
   import scope_pkg::*;
(
   input  wire        CLK_25MHZ,
   input  wire        reset_from_key,
   input  key_event_t key_event,
   output held_keys_t held_keys,
   output chan_mode_u raw_mode,
   output chan_mode_u mod_mode
);

   localparam int NUM_KEYS = $bits(held_keys_t);

   // index n-1 holds the codes of key n
   localparam logic [7:0] MAKE_CODE [NUM_KEYS] = '{
      `SC_MAKE_1, `SC_MAKE_2, `SC_MAKE_3, `SC_MAKE_4,
      `SC_MAKE_5, `SC_MAKE_6, `SC_MAKE_7, `SC_MAKE_8
   };

   localparam logic [7:0] BREAK_CODE [NUM_KEYS] = '{
      `SC_BREAK_1, `SC_BREAK_2, `SC_BREAK_3, `SC_BREAK_4,
      `SC_BREAK_5, `SC_BREAK_6, `SC_BREAK_7, `SC_BREAK_8
   };

   logic [NUM_KEYS-1:0] make_hit;
   logic [NUM_KEYS-1:0] break_hit;
   logic [NUM_KEYS-1:0] held_q;
   logic [2:0]          make_idx;     // key number minus one

   //////////////////////////////////////////////////////////////////////
   // event decode
   //////////////////////////////////////////////////////////////////////

   // codes are all distinct, at most one hit per event
   always_comb
   begin
      make_idx = '0;
      for (int i = 0; i < NUM_KEYS; i++)
      begin
         make_hit[i]  = key_event.ready && (key_event.event_type == MAKE_CODE[i]);
         break_hit[i] = key_event.ready && (key_event.event_type == BREAK_CODE[i]);
         if (make_hit[i])
         begin
            make_idx = 3'(i);
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // held key levels
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_q <= '0;
      end
      else
      begin
         held_q <= (held_q | make_hit) & ~break_hit;   // set on make, clear on break
      end
   end

   assign held_keys = held_q;

   //////////////////////////////////////////////////////////////////////
   // selector latches
   //////////////////////////////////////////////////////////////////////

   // keys 1-4 pick the raw waveform, keys 5-8 the modulation
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         raw_mode.wave       <= SAW;
         mod_mode.modulation <= ASK;
      end
      else if (|make_hit)
      begin
         if (!make_idx[2])
         begin
            raw_mode.wave <= wave_sel_e'(make_idx[1:0]);
         end
         else
         begin
            mod_mode.modulation <= mod_sel_e'(make_idx[1:0]);   // key 5 is ask
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/symbol_timing.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module symbol_timing (
   input  wire  CLK_25MHZ,
   input  wire  reset_from_key,
   output logic sample_strobe,
   output logic symbol_strobe,
   output logic data_bit
);

   localparam int DIV_W  = $clog2(`SAMPLE_DIV);
   localparam int SYMB_W = $clog2(`SYMBOL_SAMPLES);

   logic [DIV_W-1:0]   clk_cnt;
   logic [SYMB_W-1:0]  samp_cnt;
   logic [`LFSR_W-1:0] lfsr;

   //////////////////////////////////////////////////////////////////////
   // strobe dividers
   //////////////////////////////////////////////////////////////////////

   // first cycle out of reset sees count 0
   assign sample_strobe = (clk_cnt == DIV_W'(`SAMPLE_DIV - 1));
   assign symbol_strobe = sample_strobe && (samp_cnt == SYMB_W'(`SYMBOL_SAMPLES - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         clk_cnt  <= '0;
         samp_cnt <= '0;
      end
      else
      begin
         clk_cnt <= sample_strobe ? '0 : clk_cnt + 1'b1;
         if (sample_strobe)
         begin
            samp_cnt <= symbol_strobe ? '0 : samp_cnt + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // data bit lfsr
   //////////////////////////////////////////////////////////////////////

   // fibonacci form, feedback enters at the msb
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr <= `LFSR_SEED;
      end
      else if (symbol_strobe)
      begin
         lfsr <= {^(lfsr & `LFSR_TAPS), lfsr[`LFSR_W-1:1]};
      end
   end

   assign data_bit = lfsr[0];   // one bit per symbol

endmodule

`default_nettype wire

/* verilog/dds_channel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module dds_channel
   import scope_pkg::*;
#(
   parameter bit MODULATED = 1'b0
) (
   input  wire                CLK_25MHZ,
   input  wire                reset_from_key,
   input  chan_mode_u         mode,
   input  wire                data_bit,
   input  wire                sample_strobe,
   output logic [`PLOT_W-1:0] plot,
   output logic               sample_valid
);

   localparam int W = `WAVE_W;

   localparam logic [W-1:0] POS_FULL = {1'b0, {(W-1){1'b1}}};   // +2047
   localparam logic [W-1:0] NEG_FULL = {1'b1, {(W-1){1'b0}}};   // -2048, also half scale

   logic [`PHASE_W-1:0] phase;
   logic [`PHASE_W-1:0] phase_inc;
   logic [W-1:0]        p;
   logic [W-1:0]        dbl_p;
   logic signed [W-1:0] saw;
   logic signed [W-1:0] tri_wave;
   logic signed [W-1:0] square;
   logic signed [W-1:0] wave;

   //////////////////////////////////////////////////////////////////////
   // phase accumulator
   //////////////////////////////////////////////////////////////////////

   // fsk mark doubles the step while the bit is 1
   always_comb
   begin
      phase_inc = `BASE_INC;
      if (MODULATED && (mode.modulation == FSK) && data_bit)
      begin
         phase_inc = `FSK_INC;
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         phase <= '0;
      end
      else
      begin
         phase <= phase + phase_inc;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // wave shaping
   //////////////////////////////////////////////////////////////////////

   assign p     = phase[`PHASE_W-1 -: W];
   assign dbl_p = {p[W-2:0], 1'b0};           // 2p, wrapped

   assign saw = {~p[W-1], p[W-2:0]};

   // rising half 2p-2048, falling half 6143-2p, both mod 4096
   assign tri_wave = p[W-1] ? (POS_FULL - dbl_p) : (dbl_p - NEG_FULL);

   assign square = p[W-1] ? NEG_FULL : POS_FULL;

   always_comb
   begin
      wave = saw;
      if (MODULATED)
      begin
         case (mode.modulation)
            ASK:     wave = data_bit ? saw : '0;
            FSK:     wave = saw;                  // frequency moved in the accumulator
            BPSK:    wave = data_bit ? saw : ~saw;
            DIRECT:  wave = data_bit ? POS_FULL : NEG_FULL;
            default: wave = saw;
         endcase
      end
      else
      begin
         case (mode.wave)
            SAW:       wave = saw;
            TRIANGLE:  wave = tri_wave;
            SQUARE:    wave = square;
            RAMP_DOWN: wave = ~saw;
            default:   wave = saw;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // plot sample register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         plot         <= '0;
         sample_valid <= 1'b0;
      end
      else
      begin
         sample_valid <= sample_strobe;            // one cycle after the strobe
         if (sample_strobe)
         begin
            // offset binary, top bits only
            plot <= {~wave[W-1], wave[W-2 -: `PLOT_W-1]};
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/scope_signal_top.sv */
`timescale 1ns/1ps
`default_nettype none

module scope_signal_top
   import scope_pkg::*;
(
   input  wire           CLK_25MHZ,
   input  wire           reset_from_key,
   input  key_event_t    key_event,
   output held_keys_t    held_keys,
   output logic          tx_bit,
   output logic          sample_valid,
   output scope_sample_t scope_sample
);

   chan_mode_u raw_mode;
   chan_mode_u mod_mode;
   logic       sample_strobe;

   //////////////////////////////////////////////////////////////////////
   // control
   //////////////////////////////////////////////////////////////////////

   keyboard_panel u_panel (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .key_event      (key_event),
      .held_keys      (held_keys),
      .raw_mode       (raw_mode),
      .mod_mode       (mod_mode)
   );

   // symbol strobe only paces the lfsr inside
   symbol_timing u_timing (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .sample_strobe  (sample_strobe),
      .symbol_strobe  (),
      .data_bit       (tx_bit)
   );

   //////////////////////////////////////////////////////////////////////
   // channels
   //////////////////////////////////////////////////////////////////////

   dds_channel #(.MODULATED(1'b0)) u_raw_chan (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .mode           (raw_mode),
      .data_bit       (tx_bit),        // ignored on the raw side
      .sample_strobe  (sample_strobe),
      .plot           (scope_sample.raw_plot),
      .sample_valid   (sample_valid)
   );

   dds_channel #(.MODULATED(1'b1)) u_mod_chan (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .mode           (mod_mode),
      .data_bit       (tx_bit),
      .sample_strobe  (sample_strobe),
      .plot           (scope_sample.mod_plot),
      .sample_valid   ()                // same strobe as the raw channel
   );

endmodule

`default_nettype wire

/* verif/tb_scope_signal.sv */
`timescale 1ns/1ps
`default_nettype none

`include "scope_params.svh"

module tb_scope_signal
   import scope_pkg::*;
();

   localparam logic [7:0] MAKE_CODES [8] = '{
      `SC_MAKE_1, `SC_MAKE_2, `SC_MAKE_3, `SC_MAKE_4,
      `SC_MAKE_5, `SC_MAKE_6, `SC_MAKE_7, `SC_MAKE_8
   };
   localparam logic [7:0] BREAK_CODES [8] = '{
      `SC_BREAK_1, `SC_BREAK_2, `SC_BREAK_3, `SC_BREAK_4,
      `SC_BREAK_5, `SC_BREAK_6, `SC_BREAK_7, `SC_BREAK_8
   };
   localparam logic [`LFSR_W-1:0] TAPS = `LFSR_TAPS;

   logic          CLK_25MHZ;
   logic          reset_from_key;
   key_event_t    key_event;
   held_keys_t    held_keys;
   logic          tx_bit;
   logic          sample_valid;
   scope_sample_t scope_sample;

   // reference model state, one cycle at a time
   int                  m_cycle;
   logic [`PHASE_W-1:0] m_raw_phase;
   logic [`PHASE_W-1:0] m_mod_phase;
   logic [`LFSR_W-1:0]  m_lfsr;
   wave_sel_e           m_wave;
   mod_sel_e            m_mod;
   logic [7:0]          m_held;
   logic                exp_valid;
   scope_sample_t       exp_sample;
   bit                  sym_seen;
   bit                  model_live = 1'b0;

   logic [31:0] rng_state = 32'hde7f;
   logic        tx_bits [$];        // tx_bit of each new symbol
   string       test_name;
   int          held_errs    = 0;
   int          sample_errs  = 0;
   int          bit_errs     = 0;
   int          timeout_errs = 0;

   scope_signal_top u_dut (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .key_event      (key_event),
      .held_keys      (held_keys),
      .tx_bit         (tx_bit),
      .sample_valid   (sample_valid),
      .scope_sample   (scope_sample)
   );

   initial CLK_25MHZ = 1'b0;
   always #20 CLK_25MHZ = ~CLK_25MHZ;   // 25 MHz

   //////////////////////////////////////////////////////////////////////
   // random source and reference functions
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] galois_step(input logic [31:0] state);
      galois_step = state >> 1;
      if (state[0])
      begin
         galois_step = galois_step ^ 32'h8020_0003;
      end
   endfunction

   task automatic take_bits(input int n, output int unsigned value);
      value = 0;
      for (int i = 0; i < n; i++)
      begin
         value     = (value << 1) | 32'(rng_state[0]);
         rng_state = galois_step(rng_state);   // one step per bit
      end
   endtask

   // shift right, feedback from the tapped bits into the msb
   function automatic logic [`LFSR_W-1:0] lfsr_next(input logic [`LFSR_W-1:0] s);
      logic fb;
      fb = 1'b0;
      for (int b = 0; b < `LFSR_W; b++)
      begin
         if (TAPS[b])
         begin
            fb = fb ^ s[b];
         end
      end
      lfsr_next = {fb, s[`LFSR_W-1:1]};
   endfunction

   function automatic logic [7:0] expected_plot(input logic [`PHASE_W-1:0] phase,
                                                input bit modulated, input wave_sel_e wsel,
                                                input mod_sel_e msel, input logic data);
      int          p;
      int          saw;
      int          w;
      logic [11:0] offset;
      p   = int'(phase[`PHASE_W-1 -: `WAVE_W]);
      saw = p - 2048;                     // msb flipped, read signed
      if (!modulated)
      begin
         case (wsel)
            SAW:      w = saw;
            TRIANGLE: w = (p < 2048) ? (2 * p - 2048) : (6143 - 2 * p);
            SQUARE:   w = (p < 2048) ? 2047 : -2048;
            default:  w = -saw - 1;       // inverse of the saw
         endcase
      end
      else
      begin
         case (msel)
            ASK:     w = data ? saw : 0;
            FSK:     w = saw;
            BPSK:    w = data ? saw : -saw - 1;
            default: w = data ? 2047 : -2048;
         endcase
      end
      offset        = 12'(w + 2048);      // offset binary
      expected_plot = offset[11:4];
   endfunction

   //////////////////////////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////////////////////////

   task automatic check_held(input string name, input held_keys_t expected,
                             input held_keys_t actual);
      if (actual !== expected)
      begin
         held_errs++;
         $display("ERR %s: expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic check_sample(input string name, input scope_sample_t expected,
                               input scope_sample_t actual);
      if (actual !== expected)
      begin
         sample_errs++;
         $display("ERR %s: expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         bit_errs++;
         $display("ERR %s: expected %b actual %b", name, expected, actual);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // reference model and checker
   //////////////////////////////////////////////////////////////////////

   always @(posedge CLK_25MHZ)
   begin : model_update
      bit                  strobe;
      bit                  symbol;
      logic [`PHASE_W-1:0] inc;
      if (reset_from_key)
      begin
         m_cycle     = 1;                 // next cycle is the first after release
         m_raw_phase = '0;
         m_mod_phase = '0;
         m_lfsr      = `LFSR_SEED;
         m_wave      = SAW;
         m_mod       = ASK;
         m_held      = '0;
         exp_valid   = 1'b0;
         exp_sample  = '0;
         sym_seen    = 1'b0;
      end
      else
      begin
         strobe    = (m_cycle % `SAMPLE_DIV) == 0;
         symbol    = strobe && (((m_cycle / `SAMPLE_DIV) % `SYMBOL_SAMPLES) == 0);
         exp_valid = strobe;
         sym_seen  = symbol;
         if (strobe)
         begin
            exp_sample.raw_plot = expected_plot(m_raw_phase, 1'b0, m_wave, m_mod, m_lfsr[0]);
            exp_sample.mod_plot = expected_plot(m_mod_phase, 1'b1, m_wave, m_mod, m_lfsr[0]);
         end
         inc         = ((m_mod == FSK) && m_lfsr[0]) ? `FSK_INC : `BASE_INC;
         m_raw_phase = m_raw_phase + `BASE_INC;
         m_mod_phase = m_mod_phase + inc;
         if (symbol)
         begin
            m_lfsr = lfsr_next(m_lfsr);
         end
         for (int i = 0; i < 8; i++)
         begin
            if (key_event.ready && (key_event.event_type == MAKE_CODES[i]))
            begin
               m_held[i] = 1'b1;
               case (i)
                  0:       m_wave = SAW;
                  1:       m_wave = TRIANGLE;
                  2:       m_wave = SQUARE;
                  3:       m_wave = RAMP_DOWN;
                  4:       m_mod  = ASK;
                  5:       m_mod  = FSK;
                  6:       m_mod  = BPSK;
                  default: m_mod  = DIRECT;
               endcase
            end
            if (key_event.ready && (key_event.event_type == BREAK_CODES[i]))
            begin
               m_held[i] = 1'b0;          // break only drops the level
            end
         end
         m_cycle++;
      end
      model_live = 1'b1;
   end

   // outputs are settled by the falling edge
   always @(negedge CLK_25MHZ)
   begin
      if (model_live)
      begin
         check_held({test_name, " held_keys"}, held_keys_t'(m_held), held_keys);
         check_bit({test_name, " tx_bit"}, m_lfsr[0], tx_bit);
         check_bit({test_name, " sample_valid"}, exp_valid, sample_valid);
         if (exp_valid)
         begin
            check_sample({test_name, " scope_sample"}, exp_sample, scope_sample);
         end
         if (sym_seen)
         begin
            tx_bits.push_back(tx_bit);
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic send_event(input logic [7:0] code);
      @(posedge CLK_25MHZ);
      #2;
      key_event = '{ready: 1'b1, event_type: code};
      @(posedge CLK_25MHZ);
      #2;
      key_event = '0;                     // strobe lasts one cycle
   endtask

   task automatic wait_samples(input int count, input string what);
      int seen;
      int cycles;
      seen   = 0;
      cycles = 0;
      while ((seen < count) && (cycles < (count + 4) * `SAMPLE_DIV))
      begin
         @(posedge CLK_25MHZ);
         #1;
         if (sample_valid)
         begin
            seen++;
         end
         cycles++;
      end
      if (seen < count)
      begin
         timeout_errs++;
         $display("timeout: only %0d of %0d samples arrived during %s", seen, count, what);
      end
   endtask

   initial
   begin : stimulus
      int unsigned pick;
      int unsigned brk;
      int unsigned unk;
      int unsigned gap;
      int unsigned rnd_code;
      logic [7:0]  code;
      int          cycles;
      int          ones;
      reset_from_key = 1'b1;
      key_event      = '0;
      test_name      = "reset";
      repeat (5) @(posedge CLK_25MHZ);
      #2;
      reset_from_key = 1'b0;

      test_name = "after_reset";
      wait_samples(4, test_name);

      // makes, breaks and the odd unknown code
      test_name = "random_keys";
      repeat (60)
      begin
         take_bits(3, pick);
         take_bits(1, brk);
         take_bits(3, unk);
         if (unk == 0)
         begin
            take_bits(8, rnd_code);
            code = rnd_code[7:0];
         end
         else
         begin
            code = (brk != 0) ? BREAK_CODES[pick] : MAKE_CODES[pick];
         end
         send_event(code);
         take_bits(3, gap);
         repeat (gap) @(posedge CLK_25MHZ);
      end
      wait_samples(2, test_name);

      // 140 samples cover a full carrier period
      for (int k = 0; k < 8; k++)
      begin
         test_name = $sformatf("%s_key%0d", (k < 4) ? "raw_wave" : "mod_scheme", k + 1);
         send_event(MAKE_CODES[k]);
         wait_samples(140, test_name);
         send_event(BREAK_CODES[k]);
      end

      test_name = "tx_sequence";
      cycles    = 0;
      while ((tx_bits.size() < 64) && (cycles < 64 * `SYMBOL_SAMPLES * `SAMPLE_DIV))
      begin
         @(posedge CLK_25MHZ);
         cycles++;
      end
      if (tx_bits.size() < 64)
      begin
         timeout_errs++;
         $display("timeout: only %0d symbols seen on tx_bit", tx_bits.size());
      end
      for (int i = 0; i + 31 < tx_bits.size(); i++)
      begin
         check_bit("tx_period", tx_bits[i], tx_bits[i + 31]);
      end
      ones = 0;
      for (int i = 0; (i < 31) && (i < tx_bits.size()); i++)
      begin
         if (tx_bits[i])
         begin
            ones++;
         end
      end
      if (ones != 16)                     // m-sequence balance
      begin
         bit_errs++;
         $display("ERR %s ones in 31 symbols: expected 16 actual %0d", test_name, ones);
      end

      $display("errors: held_keys %0d, scope_sample %0d, bit %0d, timeout %0d",
               held_errs, sample_errs, bit_errs, timeout_errs);
      if ((held_errs + sample_errs + bit_errs + timeout_errs) == 0)
      begin
         $display("Simulation passed");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/scope_pkg.sv
verilog/keyboard_panel.sv
verilog/symbol_timing.sv
verilog/dds_channel.sv
verilog/scope_signal_top.sv
verif/tb_scope_signal.sv

/* run_sim.sh */
#!/bin/sh
# build and run the scope signal testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
MDIR=obj_dir

verilator --binary --timing --top-module tb_scope_signal --Mdir "$MDIR" -f vlog.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

"./$MDIR/Vtb_scope_signal" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
